//--- mempool_vectors.txt
// phase port op(0 read, 1 write) address wdata be id expected_word, all hex
// Phase 0 ends the list, the expected word of a write is the merged bank word
2 0 1 00000000 11111111 f 1 11111111
2 0 0 00000000 00000000 f 2 11111111
2 1 1 0000002c 22222222 f 3 22222222
2 1 0 0000002c 00000000 f 4 22222222
3 2 1 00000040 a5a5a5a5 f 1 a5a5a5a5
3 2 1 00000040 0000bbcc 3 2 a5a5bbcc
3 2 0 00000040 00000000 0 3 a5a5bbcc
3 3 1 0000005c 12345678 f 1 12345678
3 3 1 0000005c 00ff0000 4 2 12ff5678
3 3 0 0000005c 00000000 0 3 12ff5678
4 0 1 000000a0 c0de0000 f 0 c0de0000
4 0 1 000000a4 c0de0101 f 1 c0de0101
4 0 1 000000a8 c0de0202 f 2 c0de0202
4 0 1 000000ac c0de0303 f 3 c0de0303
4 0 1 000000b0 c0de0404 f 4 c0de0404
4 0 1 000000b4 c0de0505 f 5 c0de0505
4 0 1 000000b8 c0de0606 f 6 c0de0606
4 0 1 000000bc c0de0707 f 7 c0de0707
5 1 0 000000a0 00000000 0 0 c0de0000
5 1 0 000000ac 00000000 0 1 c0de0303
5 1 0 000000b4 00000000 0 2 c0de0505
5 2 0 fffff8a4 00000000 0 3 c0de0101
5 2 0 000000b8 00000000 0 4 c0de0606
5 3 0 800000b0 00000000 0 5 c0de0404
5 3 0 123450a8 00000000 0 6 c0de0202
5 3 0 0000f8bc 00000000 0 7 c0de0707
6 0 1 00000150 60000000 f 1 60000000
6 1 1 00000170 61111111 f 2 61111111
6 2 1 00000190 62222222 f 3 62222222
6 3 1 000001b0 63333333 f 4 63333333
7 0 0 00000150 00000000 0 1 60000000
7 0 0 000000a4 00000000 0 2 c0de0101
7 0 0 00000000 00000000 0 9 11111111
7 1 0 00000170 00000000 0 3 61111111
7 1 0 000000b8 00000000 0 4 c0de0606
7 1 0 0000002c 00000000 0 a 22222222
7 2 0 00000190 00000000 0 5 62222222
7 2 1 00000040 00990000 4 6 a599bbcc
7 3 0 000001b0 00000000 0 7 63333333
7 3 0 0000005c 00000000 0 8 12ff5678
0 0 0 00000000 00000000 0 0 00000000

//--- sources.f
mempool_pkg.sv
tcdm_addr_decode.sv
tcdm_rr_arbiter.sv
tcdm_req_xbar.sv
mempool_tile.sv
tcdm_resp_xbar.sv
mempool.sv
tb_clock_gen.sv
tb_mempool.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile the cluster testbench with Verilator, run it, pass on TEST OK
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --timescale 1ns/1ns \
    --top-module tb_mempool -f sources.f \
  && ./obj_dir/Vtb_mempool | tee /dev/stderr | grep -qx "TEST OK" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

//--- tb_mempool.sv
/*
 * Vector-driven testbench for the TCDM cluster
 * Per-port driver, response scoreboard keyed by id,
 * stall stability check, latency check and random back-pressure
 */
`timescale 1ns/1ns
`default_nettype none

module tb_mempool;

  import mempool_pkg::*;

  localparam int unsigned VecWords   = 8;
  localparam int unsigned MaxVecs    = 48;
  localparam int unsigned NumIds     = 16;
  localparam int unsigned TimeoutCyc = 400;

  logic                       clk;
  logic                       rst;
  logic        [NumTiles-1:0] req_valid;
  logic        [NumTiles-1:0] req_ready;
  addr_t       [NumTiles-1:0] req_addr;
  tcdm_op_e    [NumTiles-1:0] req_op;
  data_t       [NumTiles-1:0] req_wdata;
  strb_t       [NumTiles-1:0] req_be;
  reorder_id_t [NumTiles-1:0] req_id;
  logic        [NumTiles-1:0] resp_valid;
  logic        [NumTiles-1:0] resp_ready;
  data_t       [NumTiles-1:0] resp_rdata;
  reorder_id_t [NumTiles-1:0] resp_id;

  // Eight words per vector: phase port op addr wdata be id expected
  logic [31:0] vec_mem [MaxVecs*VecWords];
  data_t       exp_word [NumTiles][NumIds];
  int          issued [NumTiles][NumIds];
  int          answered [NumTiles][NumIds];
  int          acc_cycle [NumTiles][NumIds];
  bit          held_v [NumTiles];
  data_t       held_d [NumTiles];
  reorder_id_t held_i [NumTiles];
  int          cycle;
  int          n_sent;
  int          n_recv;
  int          errors;
  int          checks;
  int          mon_errors;
  int          mon_checks;
  bit          bp_en;
  bit          lat_check;
  bit          timed_out;

  tb_clock_gen u_clk_gen (
    .clk_o  (clk),
    .reset_o(rst)
  );

  mempool u_dut (
    .clk_i         (clk       ),
    .reset_i       (rst       ),
    .req_valid_i   (req_valid ),
    .req_ready_o   (req_ready ),
    .req_tgt_addr_i(req_addr  ),
    .req_op_i      (req_op    ),
    .req_wdata_i   (req_wdata ),
    .req_be_i      (req_be    ),
    .req_id_i      (req_id    ),
    .resp_valid_o  (resp_valid),
    .resp_ready_i  (resp_ready),
    .resp_rdata_o  (resp_rdata),
    .resp_id_o     (resp_id   )
  );

  // One clock edge, with a fresh response-ready pattern
  task automatic tick();
    @(posedge clk);
    resp_ready <= bp_en ? NumTiles'($urandom) : '1;
  endtask

  task automatic run_phase(input int ph);
    int                  q [NumTiles][$];
    logic [NumTiles-1:0] busy;
    tile_id_t            port;
    reorder_id_t         vid;
    int                  b;
    int                  t;
    int                  left;
    bit                  can_issue;
    lat_check = (ph == 2);
    bp_en     = (ph == 7);
    busy      = '0;
    left      = 0;
    for (int k = 0; k < MaxVecs && vec_mem[k*VecWords] != 0; k++) begin
      if (vec_mem[k*VecWords] == ph) begin
        port = tile_id_t'(vec_mem[k*VecWords+1]);
        q[port].push_back(k * VecWords);
        left++;
      end
    end
    t = 0;
    while ((busy != '0 || left > 0) && t < TimeoutCyc) begin
      tick();
      t++;
      for (int p = 0; p < NumTiles; p++) begin
        if (busy[p] && req_ready[p]) begin
          acc_cycle[p][req_id[p]] = cycle;
          busy[p] = 1'b0;
        end
        // Phase 2 keeps exactly one request in the whole cluster
        can_issue = q[p].size() > 0 && !busy[p] &&
                    (!lat_check || (n_sent == n_recv && busy == '0));
        if (can_issue) begin
          b   = q[p].pop_front();
          vid = reorder_id_t'(vec_mem[b+6]);
          req_op[p]    <= tcdm_op_e'(vec_mem[b+2][0]);
          req_addr[p]  <= vec_mem[b+3];
          req_wdata[p] <= vec_mem[b+4];
          req_be[p]    <= strb_t'(vec_mem[b+5]);
          req_id[p]    <= vid;
          exp_word[p][vid] = vec_mem[b+7];
          issued[p][vid]++;
          n_sent++;
          left--;
          busy[p] = 1'b1;
        end
        req_valid[p] <= busy[p];
      end
    end
    if (busy != '0 || left > 0) begin
      timed_out = 1'b1;
      $display("TIMEOUT: phase %0d requests were not accepted in time", ph);
    end
    t = 0;
    while (!timed_out && n_recv != n_sent && t < TimeoutCyc) begin
      tick();
      t++;
    end
    if (n_recv != n_sent) begin
      timed_out = 1'b1;
      for (int p = 0; p < NumTiles; p++) begin
        for (int id = 0; id < NumIds; id++) begin
          if (issued[p][id] != answered[p][id]) begin
            $display("TIMEOUT: port %0d id %0d never answered", p, id);
          end
        end
      end
    end
    bp_en = 1'b0;
    $display("Phase %0d finished: %0d responses so far, %0d errors so far",
             ph, n_recv, errors + mon_errors);
  endtask

  // Scoreboard, sampled on the edge where the handshake happens
  always @(posedge clk) begin : monitor
    reorder_id_t id;
    cycle <= cycle + 1;
    for (int p = 0; p < NumTiles; p++) begin
      if (held_v[p]) begin
        mon_checks++;
        assert (resp_valid[p] && resp_rdata[p] == held_d[p] && resp_id[p] == held_i[p])
        else begin
          mon_errors++;
          $display("MISMATCH at %0t: port %0d response changed while stalled", $time, p);
        end
      end
      held_v[p] = resp_valid[p] && !resp_ready[p];
      held_d[p] = resp_rdata[p];
      held_i[p] = resp_id[p];
      if (resp_valid[p] && resp_ready[p]) begin
        id = resp_id[p];
        mon_checks++;
        assert (answered[p][id] < issued[p][id])
        else begin
          mon_errors++;
          $display("ERROR at %0t: port %0d returned id %0d with no request outstanding",
                   $time, p, id);
        end
        assert (resp_rdata[p] == exp_word[p][id])
        else begin
          mon_errors++;
          $display("MISMATCH at %0t: port %0d id %0d data %h, expected %h",
                   $time, p, id, resp_rdata[p], exp_word[p][id]);
        end
        if (lat_check) begin
          assert (cycle - acc_cycle[p][id] == 4)
          else begin
            mon_errors++;
            $display("MISMATCH at %0t: port %0d id %0d latency %0d cycles, expected 4",
                     $time, p, id, cycle - acc_cycle[p][id]);
          end
        end
        answered[p][id]++;
        n_recv++;
      end
    end
  end

  initial begin
    int t;
    void'($urandom(32'h07862383));
    req_valid  = '0;
    req_addr   = '0;
    req_wdata  = '0;
    req_be     = '0;
    req_id     = '0;
    resp_ready = '1;
    for (int p = 0; p < NumTiles; p++) begin
      req_op[p] = TCDM_READ;
    end
    $readmemh("mempool_vectors.txt", vec_mem);
    tick();
    t = 1;
    while (rst && t < 10) begin
      tick();
      t++;
    end
    if (rst) begin
      timed_out = 1'b1;
      $display("TIMEOUT: reset was never released");
    end else begin
      checks++;
      assert (resp_valid == '0 && req_ready == '1)
      else begin
        errors++;
        $display("MISMATCH at %0t: after reset resp_valid %b, req_ready %b",
                 $time, resp_valid, req_ready);
      end
      $display("Phase 1 finished: reset state, %0d errors so far", errors);
    end
    for (int ph = 2; ph <= 7; ph++) begin
      if (!timed_out) begin
        run_phase(ph);
      end
    end
    $display("Checks %0d, errors %0d, responses %0d of %0d, timeout %0d",
             checks + mon_checks, errors + mon_errors, n_recv, n_sent, timed_out);
    if (errors + mon_errors == 0 && !timed_out) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule : tb_mempool

`default_nettype wire

//--- tb_clock_gen.sv
/*
 * Testbench clock and reset source
 * 4 ns clock, synchronous reset held for two rising edges
 */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  initial begin
    reset_o = 1'b1;
    repeat (2) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule : tb_clock_gen

`default_nettype wire

//--- mempool.sv
/*
 * Cluster top level
 * Address decode, request crossbar, tiles and response crossbar
 * chained as four registered stages
 */
`timescale 1ns/1ns
`default_nettype none

module mempool (
  input  logic                                                  clk_i,
  input  logic                                                  reset_i,
  input  logic [mempool_pkg::NumTiles-1:0]                      req_valid_i,
  output logic [mempool_pkg::NumTiles-1:0]                      req_ready_o,
  input  mempool_pkg::addr_t       [mempool_pkg::NumTiles-1:0]  req_tgt_addr_i,
  input  mempool_pkg::tcdm_op_e    [mempool_pkg::NumTiles-1:0]  req_op_i,
  input  mempool_pkg::data_t       [mempool_pkg::NumTiles-1:0]  req_wdata_i,
  input  mempool_pkg::strb_t       [mempool_pkg::NumTiles-1:0]  req_be_i,
  input  mempool_pkg::reorder_id_t [mempool_pkg::NumTiles-1:0]  req_id_i,
  output logic [mempool_pkg::NumTiles-1:0]                      resp_valid_o,
  input  logic [mempool_pkg::NumTiles-1:0]                      resp_ready_i,
  output mempool_pkg::data_t       [mempool_pkg::NumTiles-1:0]  resp_rdata_o,
  output mempool_pkg::reorder_id_t [mempool_pkg::NumTiles-1:0]  resp_id_o
);

  import mempool_pkg::*;

  // Decode to request crossbar
  logic        [NumTiles-1:0] dec_valid;
  logic        [NumTiles-1:0] dec_ready;
  tile_id_t    [NumTiles-1:0] dec_tile;
  tile_addr_t  [NumTiles-1:0] dec_tile_addr;
  tcdm_op_e    [NumTiles-1:0] dec_op;
  data_t       [NumTiles-1:0] dec_wdata;
  strb_t       [NumTiles-1:0] dec_be;
  reorder_id_t [NumTiles-1:0] dec_id;

  // Request crossbar to tiles
  logic        [NumTiles-1:0] tile_req_valid;
  logic        [NumTiles-1:0] tile_req_ready;
  tile_addr_t  [NumTiles-1:0] tile_req_addr;
  tcdm_op_e    [NumTiles-1:0] tile_req_op;
  data_t       [NumTiles-1:0] tile_req_wdata;
  strb_t       [NumTiles-1:0] tile_req_be;
  reorder_id_t [NumTiles-1:0] tile_req_id;
  tile_id_t    [NumTiles-1:0] tile_req_ini;

  // Tiles to response crossbar
  logic        [NumTiles-1:0] tile_resp_valid;
  logic        [NumTiles-1:0] tile_resp_ready;
  data_t       [NumTiles-1:0] tile_resp_rdata;
  reorder_id_t [NumTiles-1:0] tile_resp_id;
  tile_id_t    [NumTiles-1:0] tile_resp_ini;

  for (genvar p = 0; p < NumTiles; p++) begin : gen_decode
    tcdm_addr_decode i_decode (
      .clk_i          (clk_i            ),
      .reset_i        (reset_i          ),
      .in_valid_i     (req_valid_i[p]   ),
      .in_ready_o     (req_ready_o[p]   ),
      .in_addr_i      (req_tgt_addr_i[p]),
      .in_op_i        (req_op_i[p]      ),
      .in_wdata_i     (req_wdata_i[p]   ),
      .in_be_i        (req_be_i[p]      ),
      .in_id_i        (req_id_i[p]      ),
      .out_valid_o    (dec_valid[p]     ),
      .out_ready_i    (dec_ready[p]     ),
      .out_tile_o     (dec_tile[p]      ),
      .out_tile_addr_o(dec_tile_addr[p] ),
      .out_op_o       (dec_op[p]        ),
      .out_wdata_o    (dec_wdata[p]     ),
      .out_be_o       (dec_be[p]        ),
      .out_id_o       (dec_id[p]        )
    );
  end

  tcdm_req_xbar i_req_xbar (
    .clk_i              (clk_i         ),
    .reset_i            (reset_i       ),
    .in_valid_i         (dec_valid     ),
    .in_ready_o         (dec_ready     ),
    .in_tile_i          (dec_tile      ),
    .in_tile_addr_i     (dec_tile_addr ),
    .in_op_i            (dec_op        ),
    .in_wdata_i         (dec_wdata     ),
    .in_be_i            (dec_be        ),
    .in_id_i            (dec_id        ),
    .tile_req_valid_o   (tile_req_valid),
    .tile_req_ready_i   (tile_req_ready),
    .tile_req_addr_o    (tile_req_addr ),
    .tile_req_op_o      (tile_req_op   ),
    .tile_req_wdata_o   (tile_req_wdata),
    .tile_req_be_o      (tile_req_be   ),
    .tile_req_id_o      (tile_req_id   ),
    .tile_req_ini_addr_o(tile_req_ini  )
  );

  for (genvar t = 0; t < NumTiles; t++) begin : gen_tiles
    mempool_tile i_tile (
      .clk_i          (clk_i             ),
      .reset_i        (reset_i           ),
      .req_valid_i    (tile_req_valid[t] ),
      .req_ready_o    (tile_req_ready[t] ),
      .req_addr_i     (tile_req_addr[t]  ),
      .req_op_i       (tile_req_op[t]    ),
      .req_wdata_i    (tile_req_wdata[t] ),
      .req_be_i       (tile_req_be[t]    ),
      .req_id_i       (tile_req_id[t]    ),
      .req_ini_addr_i (tile_req_ini[t]   ),
      .resp_valid_o   (tile_resp_valid[t]),
      .resp_ready_i   (tile_resp_ready[t]),
      .resp_rdata_o   (tile_resp_rdata[t]),
      .resp_id_o      (tile_resp_id[t]   ),
      .resp_ini_addr_o(tile_resp_ini[t]  )
    );
  end

  tcdm_resp_xbar i_resp_xbar (
    .clk_i               (clk_i          ),
    .reset_i             (reset_i        ),
    .tile_resp_valid_i   (tile_resp_valid),
    .tile_resp_ready_o   (tile_resp_ready),
    .tile_resp_rdata_i   (tile_resp_rdata),
    .tile_resp_id_i      (tile_resp_id   ),
    .tile_resp_ini_addr_i(tile_resp_ini  ),
    .out_valid_o         (resp_valid_o   ),
    .out_ready_i         (resp_ready_i   ),
    .out_rdata_o         (resp_rdata_o   ),
    .out_id_o            (resp_id_o      )
  );

endmodule : mempool

`default_nettype wire

//--- tcdm_resp_xbar.sv
/*
 * Response crossbar from tiles back to initiators
 * Per initiator a round-robin arbiter over tiles answering it,
 * winner held in one output register
 */
`timescale 1ns/1ns
`default_nettype none

module tcdm_resp_xbar (
  input  logic                                                  clk_i,
  input  logic                                                  reset_i,
  input  logic [mempool_pkg::NumTiles-1:0]                      tile_resp_valid_i,
  output logic [mempool_pkg::NumTiles-1:0]                      tile_resp_ready_o,
  input  mempool_pkg::data_t       [mempool_pkg::NumTiles-1:0]  tile_resp_rdata_i,
  input  mempool_pkg::reorder_id_t [mempool_pkg::NumTiles-1:0]  tile_resp_id_i,
  input  mempool_pkg::tile_id_t    [mempool_pkg::NumTiles-1:0]  tile_resp_ini_addr_i,
  output logic [mempool_pkg::NumTiles-1:0]                      out_valid_o,
  input  logic [mempool_pkg::NumTiles-1:0]                      out_ready_i,
  output mempool_pkg::data_t       [mempool_pkg::NumTiles-1:0]  out_rdata_o,
  output mempool_pkg::reorder_id_t [mempool_pkg::NumTiles-1:0]  out_id_o
);

  import mempool_pkg::*;

  // Indexed [initiator][tile]
  logic [NumTiles-1:0][NumTiles-1:0] req_mat;
  logic [NumTiles-1:0][NumTiles-1:0] gnt_mat;
  tile_id_t [NumTiles-1:0]           gnt_idx;
  logic [NumTiles-1:0]               out_ready;

  for (genvar i = 0; i < NumTiles; i++) begin : gen_ini_port
    for (genvar t = 0; t < NumTiles; t++) begin : gen_req
      assign req_mat[i][t] = tile_resp_valid_i[t] &&
                             (tile_resp_ini_addr_i[t] == tile_id_t'(i));
    end

    assign out_ready[i] = !out_valid_o[i] || out_ready_i[i];

    tcdm_rr_arbiter i_arb (
      .clk_i    (clk_i       ),
      .reset_i  (reset_i     ),
      .req_i    (req_mat[i]  ),
      .gnt_o    (gnt_mat[i]  ),
      .gnt_idx_o(gnt_idx[i]  ),
      .advance_i(out_ready[i])
    );

    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        out_valid_o[i] <= 1'b0;
      end else if (out_ready[i]) begin
        out_valid_o[i] <= |req_mat[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (out_ready[i] && (|req_mat[i])) begin
        out_rdata_o[i] <= tile_resp_rdata_i[gnt_idx[i]];
        out_id_o[i]    <= tile_resp_id_i[gnt_idx[i]];
      end
    end
  end

  // Tile drains only when granted by the initiator it answers
  for (genvar t = 0; t < NumTiles; t++) begin : gen_tile_ready
    assign tile_resp_ready_o[t] = gnt_mat[tile_resp_ini_addr_i[t]][t] &&
                                  out_ready[tile_resp_ini_addr_i[t]];
  end

endmodule : tcdm_resp_xbar

`default_nettype wire

//--- mempool_tile.sv
/*
 * Tile with two word-wide TCDM banks
 * Byte-enabled writes, synchronous reads, held response register
 * that returns the post-write word with id and initiator
 */
`timescale 1ns/1ns
`default_nettype none

module mempool_tile (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     req_valid_i,
  output logic                     req_ready_o,
  input  mempool_pkg::tile_addr_t  req_addr_i,
  input  mempool_pkg::tcdm_op_e    req_op_i,
  input  mempool_pkg::data_t       req_wdata_i,
  input  mempool_pkg::strb_t       req_be_i,
  input  mempool_pkg::reorder_id_t req_id_i,
  input  mempool_pkg::tile_id_t    req_ini_addr_i,
  output logic                     resp_valid_o,
  input  logic                     resp_ready_i,
  output mempool_pkg::data_t       resp_rdata_o,
  output mempool_pkg::reorder_id_t resp_id_o,
  output mempool_pkg::tile_id_t    resp_ini_addr_o
);

  import mempool_pkg::*;

  data_t                       mem_q [NumBanksPerTile][TCDMRowsPerBank];
  logic [BankSelWidth-1:0]     bank_sel;
  logic [TCDMAddrMemWidth-1:0] row;
  data_t                       old_word;
  data_t                       new_word;
  logic                        accept;

  assign req_ready_o = !resp_valid_o || resp_ready_i;
  assign accept      = req_valid_i && req_ready_o;

  assign bank_sel = req_addr_i[TCDMAddrMemWidth +: BankSelWidth];
  assign row      = req_addr_i[TCDMAddrMemWidth-1:0];
  assign old_word = mem_q[bank_sel][row];

  // Byte merge, reads pass the stored word through
  always_comb begin
    new_word = old_word;
    if (req_op_i == TCDM_WRITE) begin
      for (int b = 0; b < BeWidth; b++) begin
        if (req_be_i[b]) begin
          new_word[8*b +: 8] = req_wdata_i[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept && (req_op_i == TCDM_WRITE)) begin
      mem_q[bank_sel][row] <= new_word;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resp_valid_o <= 1'b0;
    end else if (req_ready_o) begin
      resp_valid_o <= req_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      resp_rdata_o    <= new_word;
      resp_id_o       <= req_id_i;
      resp_ini_addr_o <= req_ini_addr_i;
    end
  end

endmodule : mempool_tile

`default_nettype wire

//--- tcdm_req_xbar.sv
/*
 * Request crossbar from decoded ports to tiles
 * One round-robin arbiter and one output register per tile,
 * winner stored together with its initiator index
 */
`timescale 1ns/1ns
`default_nettype none

module tcdm_req_xbar (
  input  logic                                                  clk_i,
  input  logic                                                  reset_i,
  input  logic [mempool_pkg::NumTiles-1:0]                      in_valid_i,
  output logic [mempool_pkg::NumTiles-1:0]                      in_ready_o,
  input  mempool_pkg::tile_id_t    [mempool_pkg::NumTiles-1:0]  in_tile_i,
  input  mempool_pkg::tile_addr_t  [mempool_pkg::NumTiles-1:0]  in_tile_addr_i,
  input  mempool_pkg::tcdm_op_e    [mempool_pkg::NumTiles-1:0]  in_op_i,
  input  mempool_pkg::data_t       [mempool_pkg::NumTiles-1:0]  in_wdata_i,
  input  mempool_pkg::strb_t       [mempool_pkg::NumTiles-1:0]  in_be_i,
  input  mempool_pkg::reorder_id_t [mempool_pkg::NumTiles-1:0]  in_id_i,
  output logic [mempool_pkg::NumTiles-1:0]                      tile_req_valid_o,
  input  logic [mempool_pkg::NumTiles-1:0]                      tile_req_ready_i,
  output mempool_pkg::tile_addr_t  [mempool_pkg::NumTiles-1:0]  tile_req_addr_o,
  output mempool_pkg::tcdm_op_e    [mempool_pkg::NumTiles-1:0]  tile_req_op_o,
  output mempool_pkg::data_t       [mempool_pkg::NumTiles-1:0]  tile_req_wdata_o,
  output mempool_pkg::strb_t       [mempool_pkg::NumTiles-1:0]  tile_req_be_o,
  output mempool_pkg::reorder_id_t [mempool_pkg::NumTiles-1:0]  tile_req_id_o,
  output mempool_pkg::tile_id_t    [mempool_pkg::NumTiles-1:0]  tile_req_ini_addr_o
);

  import mempool_pkg::*;

  // Indexed [tile][source]
  logic [NumTiles-1:0][NumTiles-1:0] req_mat;
  logic [NumTiles-1:0][NumTiles-1:0] gnt_mat;
  tile_id_t [NumTiles-1:0]           gnt_idx;
  logic [NumTiles-1:0]               out_ready;

  for (genvar t = 0; t < NumTiles; t++) begin : gen_tile_port
    for (genvar s = 0; s < NumTiles; s++) begin : gen_req
      assign req_mat[t][s] = in_valid_i[s] && (in_tile_i[s] == tile_id_t'(t));
    end

    // Register empty or draining this cycle
    assign out_ready[t] = !tile_req_valid_o[t] || tile_req_ready_i[t];

    tcdm_rr_arbiter i_arb (
      .clk_i    (clk_i       ),
      .reset_i  (reset_i     ),
      .req_i    (req_mat[t]  ),
      .gnt_o    (gnt_mat[t]  ),
      .gnt_idx_o(gnt_idx[t]  ),
      .advance_i(out_ready[t])
    );

    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        tile_req_valid_o[t] <= 1'b0;
      end else if (out_ready[t]) begin
        tile_req_valid_o[t] <= |req_mat[t];
      end
    end

    always_ff @(posedge clk_i) begin
      if (out_ready[t] && (|req_mat[t])) begin
        tile_req_addr_o[t]     <= in_tile_addr_i[gnt_idx[t]];
        tile_req_op_o[t]       <= in_op_i[gnt_idx[t]];
        tile_req_wdata_o[t]    <= in_wdata_i[gnt_idx[t]];
        tile_req_be_o[t]       <= in_be_i[gnt_idx[t]];
        tile_req_id_o[t]       <= in_id_i[gnt_idx[t]];
        tile_req_ini_addr_o[t] <= gnt_idx[t];
      end
    end
  end

  // Only the granted source of its target tile sees ready
  for (genvar s = 0; s < NumTiles; s++) begin : gen_in_ready
    assign in_ready_o[s] = gnt_mat[in_tile_i[s]][s] && out_ready[in_tile_i[s]];
  end

endmodule : tcdm_req_xbar

`default_nettype wire

//--- tcdm_rr_arbiter.sv
/*
 * Round-robin arbiter over the tile-indexed request lines
 * Rotating priority pointer, one-hot grant plus grant index
 */
`timescale 1ns/1ns
`default_nettype none

module tcdm_rr_arbiter (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic [mempool_pkg::NumTiles-1:0]    req_i,
  output logic [mempool_pkg::NumTiles-1:0]    gnt_o,
  output mempool_pkg::tile_id_t               gnt_idx_o,
  input  logic                                advance_i
);

  import mempool_pkg::*;

  tile_id_t ptr_q;
  tile_id_t cand;
  logic     found;

  // First requester at or after the pointer with wraparound
  always_comb begin
    gnt_o     = '0;
    gnt_idx_o = '0;
    found     = 1'b0;
    cand      = ptr_q;
    for (int i = 0; i < NumTiles; i++) begin
      cand = ptr_q + tile_id_t'(i);
      if (!found && req_i[cand]) begin
        found        = 1'b1;
        gnt_o[cand]  = 1'b1;
        gnt_idx_o    = cand;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ptr_q <= '0;
    end else if (advance_i && found) begin
      ptr_q <= gnt_idx_o + tile_id_t'(1);
    end
  end

endmodule : tcdm_rr_arbiter

`default_nettype wire

//--- tcdm_addr_decode.sv
/*
 * Per-port address decode stage
 * Splits a byte address into target tile and tile-local address
 * and holds the result in a single output register
 */
`timescale 1ns/1ns
`default_nettype none

module tcdm_addr_decode (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     in_valid_i,
  output logic                     in_ready_o,
  input  mempool_pkg::addr_t       in_addr_i,
  input  mempool_pkg::tcdm_op_e    in_op_i,
  input  mempool_pkg::data_t       in_wdata_i,
  input  mempool_pkg::strb_t       in_be_i,
  input  mempool_pkg::reorder_id_t in_id_i,
  output logic                     out_valid_o,
  input  logic                     out_ready_i,
  output mempool_pkg::tile_id_t    out_tile_o,
  output mempool_pkg::tile_addr_t  out_tile_addr_o,
  output mempool_pkg::tcdm_op_e    out_op_o,
  output mempool_pkg::data_t       out_wdata_o,
  output mempool_pkg::strb_t       out_be_o,
  output mempool_pkg::reorder_id_t out_id_o
);

  import mempool_pkg::*;

  // Word interleaving: bank in tile, then tile, then row
  localparam int unsigned BankLsb = ByteOffset;
  localparam int unsigned TileLsb = ByteOffset + BankSelWidth;
  localparam int unsigned RowLsb  = ByteOffset + $clog2(NumBanks);

  logic accept;

  assign in_ready_o = !out_valid_o || out_ready_i;
  assign accept     = in_valid_i && in_ready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out_valid_o <= 1'b0;
    end else if (in_ready_o) begin
      out_valid_o <= in_valid_i;
    end
  end

  // Payload only loads on accept
  always_ff @(posedge clk_i) begin
    if (accept) begin
      out_tile_o      <= in_addr_i[TileLsb +: TileIdWidth];
      out_tile_addr_o <= {in_addr_i[BankLsb +: BankSelWidth],
                          in_addr_i[RowLsb +: TCDMAddrMemWidth]};
      out_op_o        <= in_op_i;
      out_wdata_o     <= in_wdata_i;
      out_be_o        <= in_be_i;
      out_id_o        <= in_id_i;
    end
  end

endmodule : tcdm_addr_decode

`default_nettype wire

//--- mempool_pkg.sv
/*
 * Shared localparams and scalar types of the TCDM cluster
 * Request opcode enum used on every request link
 */
`default_nettype none

package mempool_pkg;

  localparam int unsigned NumTiles         = 4;
  localparam int unsigned NumBanksPerTile  = 2;
  localparam int unsigned NumBanks         = NumTiles * NumBanksPerTile;
  localparam int unsigned DataWidth        = 32;
  localparam int unsigned AddrWidth        = 32;
  localparam int unsigned BeWidth          = DataWidth / 8;
  localparam int unsigned ByteOffset       = 2;
  localparam int unsigned TCDMRowsPerBank  = 64;
  localparam int unsigned TCDMAddrMemWidth = $clog2(TCDMRowsPerBank);

  // Derived field widths
  localparam int unsigned TileIdWidth  = $clog2(NumTiles);
  localparam int unsigned BankSelWidth = $clog2(NumBanksPerTile);
  localparam int unsigned IdWidth      = 4;

  typedef logic [AddrWidth-1:0]                     addr_t;
  typedef logic [DataWidth-1:0]                     data_t;
  typedef logic [BeWidth-1:0]                       strb_t;
  typedef logic [TileIdWidth-1:0]                   tile_id_t;
  // Bank select sits above the row index
  typedef logic [BankSelWidth+TCDMAddrMemWidth-1:0] tile_addr_t;
  typedef logic [IdWidth-1:0]                       reorder_id_t;

  typedef enum logic {
    TCDM_READ  = 1'b0,
    TCDM_WRITE = 1'b1
  } tcdm_op_e;

endpackage : mempool_pkg

`default_nettype wire
